/* Makefile */
# Verilator flow for the topic relay testbench

VERILATOR  ?= verilator
TOP        ?= relay_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall
PASS_MSG   ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
verilog/relay_pkg.sv
verilog/msg_buffer.sv
verilog/period_timer.sv
verilog/relay_fsm.sv
verilog/relay_top.sv
tests/clk_gen.sv
tests/relay_tb.sv

/* tests/clk_gen.sv */
/* Testbench clock source
   Free-running clock with a fixed period */
`default_nettype none
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS = 10
) (
    output logic clk_int
);

    initial begin
        clk_int = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_int = ~clk_int;

endmodule

`default_nettype wire

/* tests/relay_tb.sv */
/* Topic relay testbench
   Table-driven message writes, stream capture, timing and drop counting */
`default_nettype none
`timescale 1ns/1ps

module relay_tb;
    import relay_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_CASES  = 8;
    localparam int STREAMS    = 2;

    typedef struct packed {
        logic [MSG_LEN_W-1:0]  len;
        logic [PERIOD_W-1:0]   period;
        logic                  en;
        logic [DROP_CNT_W-1:0] drop;
    } entry_t;

    // Length, period, enable, drops expected over all streams of the entry
    entry_t cases_tbl [NUM_CASES] = '{
        '{8'd4,  32'd8,  1'b1, 8'd0},
        '{8'd1,  32'd2,  1'b1, 8'd0},
        '{8'd16, 32'd20, 1'b1, 8'd0},
        '{8'd0,  32'd5,  1'b1, 8'd0},
        '{8'd8,  32'd6,  1'b0, 8'd0},
        '{8'd6,  32'd4,  1'b1, 8'd2},
        '{8'd10, 32'd5,  1'b1, 8'd4},
        '{8'd32, 32'd7,  1'b1, 8'd8}
    };

    wire                   clk_int;
    logic                  rst_n;
    logic                  pll_locked;
    logic [MSG_ADDR_W-1:0] sub_addr;
    logic                  sub_ce;
    logic                  sub_we;
    logic [7:0]            sub_wdata;
    logic [MSG_LEN_W-1:0]  sub_len;
    logic                  sub_recv;
    logic [PERIOD_W-1:0]   pub_period;
    logic                  pub_en;
    logic                  pub_valid;
    logic                  pub_last;
    logic [7:0]            pub_byte;
    logic [3:0]            leds;
    logic [DROP_CNT_W-1:0] drop_count;

    logic [7:0]  exp_bytes [MAX_MSG_LEN];
    logic [7:0]  got_q [$];
    logic [31:0] lfsr_state = 32'h8dd2031e;
    int          cyc = 0;

    clk_gen #(.PERIOD_NS(CLK_PERIOD)) clk_gen_inst (.clk_int(clk_int));

    relay_top relay_top_inst (
        .clk_int    (clk_int),
        .rst_n      (rst_n),
        .pll_locked (pll_locked),
        .sub_addr   (sub_addr),
        .sub_ce     (sub_ce),
        .sub_we     (sub_we),
        .sub_wdata  (sub_wdata),
        .sub_len    (sub_len),
        .sub_recv   (sub_recv),
        .pub_period (pub_period),
        .pub_en     (pub_en),
        .pub_valid  (pub_valid),
        .pub_last   (pub_last),
        .pub_byte   (pub_byte),
        .leds       (leds),
        .drop_count (drop_count)
    );

    always @(posedge clk_int) cyc <= cyc + 1;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_len(input string name, input logic [MSG_LEN_W-1:0] got,
                             input logic [MSG_LEN_W-1:0] exp);
        if (got !== exp) fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_drop(input string name, input logic [DROP_CNT_W-1:0] got,
                              input logic [DROP_CNT_W-1:0] exp);
        if (got !== exp) fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_leds(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_period(input string name, input logic [PERIOD_W-1:0] got,
                                input logic [PERIOD_W-1:0] exp);
        if (got !== exp) fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        int k;
        b = 8'h00;
        for (k = 0; k < 8; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    // Byte 0 reaches the LEDs on the edge after its write
    task automatic write_message(input int len);
        logic [7:0] b;
        int         i;
        for (i = 0; i < len; i++) begin
            rand_byte(b);
            exp_bytes[i] = b;
            @(posedge clk_int);
            sub_addr  <= MSG_ADDR_W'(i);
            sub_ce    <= 1'b1;
            sub_we    <= 1'b1;
            sub_wdata <= b;
            @(negedge clk_int);
            if (i == 1) check_leds("leds", leds, exp_bytes[0][3:0]);
        end
        @(posedge clk_int);
        sub_ce   <= 1'b0;
        sub_we   <= 1'b0;
        sub_len  <= MSG_LEN_W'(len);
        sub_recv <= 1'b1;
        @(negedge clk_int);
        if (len > 0) check_leds("leds", leds, exp_bytes[0][3:0]);
        @(posedge clk_int);
        sub_recv <= 1'b0;
    endtask

    task automatic collect_stream(input int len, output int start_cyc);
        bit done;
        done = 1'b0;
        got_q.delete();
        @(negedge clk_int);
        while (!pub_valid) begin
            check_flag("pub_last", pub_last, 1'b0);
            @(negedge clk_int);
        end
        start_cyc = cyc;
        while (!done) begin
            if (!pub_valid) fail_run("stream stopped before its last byte");
            got_q.push_back(pub_byte);
            if (pub_last) begin
                done = 1'b1;
            end else begin
                @(negedge clk_int);
            end
        end
        check_len("stream length", MSG_LEN_W'(got_q.size()), MSG_LEN_W'(len));
        foreach (got_q[i]) check_byte("pub_byte", got_q[i], exp_bytes[i]);
    endtask

    task automatic quiet_window(input int cycles);
        repeat (cycles) begin
            @(negedge clk_int);
            check_flag("pub_valid", pub_valid, 1'b0);
        end
    endtask

    task automatic run_entry(input entry_t e);
        logic [DROP_CNT_W-1:0] base;
        int                    len;
        int                    per;
        int                    en_cyc;
        int                    start;
        int                    prev;
        int                    s;
        len = int'(e.len);
        per = int'(e.period);
        @(negedge clk_int);
        base = drop_count;
        write_message(len);
        @(posedge clk_int);
        pub_period <= e.period;
        pub_en     <= e.en;
        @(negedge clk_int);
        en_cyc = cyc;
        if (e.en && (len > 0)) begin
            prev = en_cyc;
            for (s = 0; s < STREAMS; s++) begin
                collect_stream(len, start);
                if (s == 0) begin
                    check_period("first start", PERIOD_W'(start - en_cyc), e.period + 32'd2);
                end else begin
                    // Ticks landing inside a stream are lost, so starts sit on later multiples
                    check_period("stream gap", PERIOD_W'(start - prev),
                                 e.period * PERIOD_W'(len / per + 1));
                end
                prev = start;
            end
        end else begin
            quiet_window(2 * per + MAX_MSG_LEN);
        end
        check_drop("drop_count", drop_count, base + e.drop);
        @(posedge clk_int);
        pub_en <= 1'b0;
        repeat (MAX_MSG_LEN + 4) @(posedge clk_int);
    endtask

    task automatic check_lock_loss();
        logic [7:0] b;
        int         i;
        @(posedge clk_int);
        pll_locked <= 1'b0;
        repeat (2) @(posedge clk_int);
        pub_period <= PERIOD_W'(4);
        pub_en     <= 1'b1;
        for (i = 0; i < 20; i++) begin
            rand_byte(b);
            sub_addr  <= MSG_ADDR_W'(i);
            sub_ce    <= (i < 8);
            sub_we    <= (i < 8);
            sub_wdata <= b;
            sub_len   <= MSG_LEN_W'(8);
            sub_recv  <= (i == 8);
            @(negedge clk_int);
            check_flag("pub_valid", pub_valid, 1'b0);
            check_leds("leds", leds, 4'h0);
            check_drop("drop_count", drop_count, '0);
            @(posedge clk_int);
        end
        sub_ce     <= 1'b0;
        sub_we     <= 1'b0;
        sub_recv   <= 1'b0;
        pub_en     <= 1'b0;
        pll_locked <= 1'b1;
        repeat (RST_SYNC_STAGES + 2) @(posedge clk_int);
        run_entry(entry_t'{8'd5, 32'd9, 1'b1, 8'd0});
    endtask

    function automatic longint budget_cycles();
        longint total;
        int     k;
        total = 400;
        for (k = 0; k < NUM_CASES; k++) begin
            total += longint'(cases_tbl[k].period) * STREAMS
                     * (longint'(cases_tbl[k].len) / longint'(cases_tbl[k].period) + 1);
            total += 2 * longint'(cases_tbl[k].period) + 3 * MAX_MSG_LEN + 20;
        end
        return total;
    endfunction

    initial begin : watchdog
        longint limit;
        limit = budget_cycles();
        #(limit * CLK_PERIOD);
        fail_run("timeout: the relay never finished the test table");
    end

    initial begin
        int k;
        rst_n      = 1'b0;
        pll_locked = 1'b1;
        sub_addr   = '0;
        sub_ce     = 1'b0;
        sub_we     = 1'b0;
        sub_wdata  = 8'h00;
        sub_len    = '0;
        sub_recv   = 1'b0;
        pub_period = PERIOD_W'(2);
        pub_en     = 1'b0;
        repeat (5) @(posedge clk_int);
        rst_n <= 1'b1;
        repeat (RST_SYNC_STAGES + 2) @(posedge clk_int);
        @(negedge clk_int);
        check_flag("pub_valid", pub_valid, 1'b0);
        check_leds("leds", leds, 4'h0);
        check_drop("drop_count", drop_count, '0);
        for (k = 0; k < NUM_CASES; k++) begin
            run_entry(cases_tbl[k]);
        end
        check_lock_loss();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/msg_buffer.sv */
/* Subscriber message buffer
   Byte store with registered read port, clamped message length and LED nibble */
`default_nettype none
`timescale 1ns/1ps

module msg_buffer (
    input  wire                             clk_int,
    input  wire                             rst_n,
    input  wire [relay_pkg::MSG_ADDR_W-1:0] sub_addr,
    input  wire                             sub_ce,
    input  wire                             sub_we,
    input  wire [7:0]                       sub_wdata,
    input  wire [relay_pkg::MSG_LEN_W-1:0]  sub_len,
    input  wire                             sub_recv,
    input  wire                             rd_en,
    input  wire [relay_pkg::MSG_ADDR_W-1:0] rd_addr,
    output logic [7:0]                      rd_data,
    output logic [relay_pkg::MSG_LEN_W-1:0] msg_len,
    output logic [3:0]                      leds
);
    import relay_pkg::*;

    logic [7:0]           mem [0:MAX_MSG_LEN-1];
    logic                 wr_en;
    logic [MSG_LEN_W-1:0] len_clamped;

    assign wr_en = sub_ce && sub_we;

    // Lengths beyond the buffer are cut to its size
    assign len_clamped = (sub_len > MSG_LEN_W'(MAX_MSG_LEN)) ? MSG_LEN_W'(MAX_MSG_LEN)
                                                              : sub_len;

    always_ff @(posedge clk_int) begin
        if (wr_en) begin
            mem[sub_addr] <= sub_wdata;
        end
    end

    always_ff @(posedge clk_int) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            msg_len <= '0;
        end else if (sub_recv) begin
            msg_len <= len_clamped;
        end
    end

    // LEDs mirror the low nibble of byte 0
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            leds <= 4'h0;
        end else if (wr_en && (sub_addr == '0)) begin
            leds <= sub_wdata[3:0];
        end
    end

    assert property (@(posedge clk_int) disable iff (!rst_n)
                     sub_ce |-> !$isunknown(sub_addr))
        else $error("msg_buffer: chip enable with unknown address");

endmodule

`default_nettype wire

/* verilog/period_timer.sv */
/* Transmit period timer
   Down-counter that pulses tick once every period cycles while enabled */
`default_nettype none
`timescale 1ns/1ps

module period_timer (
    input  wire                           clk_int,
    input  wire                           rst_n,
    input  wire                           en,
    input  wire [relay_pkg::PERIOD_W-1:0] period,
    output logic                          tick
);
    import relay_pkg::*;

    logic [PERIOD_W-1:0] count;

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!en) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            // Zero means freshly enabled or just expired
            if (count == '0) begin
                count <= period - PERIOD_W'(1);
            end else begin
                count <= count - PERIOD_W'(1);
            end
            tick <= (count == PERIOD_W'(1));
        end
    end

    // A period of 1 would never reach the tick condition
    assert property (@(posedge clk_int) disable iff (!rst_n)
                     en |-> (period >= PERIOD_W'(2)))
        else $error("period_timer: period below 2 while enabled");

endmodule

`default_nettype wire

/* verilog/relay_fsm.sv */
/* Publish state machine
   Streams the stored message once per tick and counts ticks lost to a busy stream */
`default_nettype none
`timescale 1ns/1ps

module relay_fsm (
    input  wire                              clk_int,
    input  wire                              rst_n,
    input  wire                              tick,
    input  wire [relay_pkg::MSG_LEN_W-1:0]   msg_len,
    input  wire [7:0]                        rd_data,
    output logic                             rd_en,
    output logic [relay_pkg::MSG_ADDR_W-1:0] rd_addr,
    output logic                             pub_valid,
    output logic                             pub_last,
    output logic [7:0]                       pub_byte,
    output logic [relay_pkg::DROP_CNT_W-1:0] drop_count
);
    import relay_pkg::*;

    logic [STATE_W-1:0]    state;
    logic [MSG_ADDR_W-1:0] last_addr;
    logic                  busy;
    logic                  issue_last;

    assign busy       = (state != ST_IDLE);
    assign issue_last = (rd_addr == last_addr);

    // READ holds the first outstanding read, STREAM the cycles with bytes leaving
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            rd_en     <= 1'b0;
            rd_addr   <= '0;
            last_addr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (tick && (msg_len != '0)) begin
                        last_addr <= MSG_ADDR_W'(msg_len - MSG_LEN_W'(1));
                        rd_addr   <= '0;
                        rd_en     <= 1'b1;
                        state     <= ST_READ;
                    end
                end
                ST_READ, ST_STREAM: begin
                    if (issue_last) begin
                        rd_en <= 1'b0;
                        state <= ST_IDLE;
                    end else begin
                        rd_addr <= rd_addr + MSG_ADDR_W'(1);
                        state   <= ST_STREAM;
                    end
                end
                default: begin
                    rd_en <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Output flags trail the read request by the buffer latency
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            pub_valid <= 1'b0;
            pub_last  <= 1'b0;
        end else begin
            pub_valid <= rd_en;
            pub_last  <= rd_en && issue_last;
        end
    end

    assign pub_byte = rd_data;

    // Saturating count of ticks that hit a running stream
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (tick && busy && (drop_count != '1)) begin
            drop_count <= drop_count + DROP_CNT_W'(1);
        end
    end

    // A stream only leaves valid through its last byte
    assert property (@(posedge clk_int) disable iff (!rst_n)
                     pub_valid && !pub_last |=> pub_valid)
        else $error("relay_fsm: stream ended before its last byte");

endmodule

`default_nettype wire

/* verilog/relay_pkg.sv */
/* Topic relay shared constants
   Message sizing, timer width, reset synchroniser depth and FSM state codes */
`default_nettype none

package relay_pkg;

    localparam int MAX_MSG_LEN     = 32;
    localparam int MSG_ADDR_W      = $clog2(MAX_MSG_LEN);
    localparam int MSG_LEN_W       = 8;
    localparam int PERIOD_W        = 32;
    localparam int RST_SYNC_STAGES = 4;
    localparam int DROP_CNT_W      = 8;

    // Publish FSM encoding
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE   = 2'd0;
    localparam logic [STATE_W-1:0] ST_READ   = 2'd1;
    localparam logic [STATE_W-1:0] ST_STREAM = 2'd2;

endpackage

`default_nettype wire

/* verilog/relay_top.sv */
/* Topic relay top level
   Lock-based reset synchroniser feeding the message buffer, period timer and publish FSM */
`default_nettype none
`timescale 1ns/1ps

module relay_top (
    input  wire                              clk_int,
    input  wire                              rst_n,
    input  wire                              pll_locked,
    input  wire [relay_pkg::MSG_ADDR_W-1:0]  sub_addr,
    input  wire                              sub_ce,
    input  wire                              sub_we,
    input  wire [7:0]                        sub_wdata,
    input  wire [relay_pkg::MSG_LEN_W-1:0]   sub_len,
    input  wire                              sub_recv,
    input  wire [relay_pkg::PERIOD_W-1:0]    pub_period,
    input  wire                              pub_en,
    output logic                             pub_valid,
    output logic                             pub_last,
    output logic [7:0]                       pub_byte,
    output logic [3:0]                       leds,
    output logic [relay_pkg::DROP_CNT_W-1:0] drop_count
);
    import relay_pkg::*;

    logic [RST_SYNC_STAGES-1:0] lock_sync;
    logic                       rst_n_int;
    logic                       tick;
    logic                       rd_en;
    logic [MSG_ADDR_W-1:0]      rd_addr;
    logic [7:0]                 rd_data;
    logic [MSG_LEN_W-1:0]       msg_len;

    // Loss of lock drops the internal reset on the next edge
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            lock_sync <= '0;
        end else if (!pll_locked) begin
            lock_sync <= '0;
        end else begin
            lock_sync <= {lock_sync[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_n_int = lock_sync[RST_SYNC_STAGES-1];

    msg_buffer msg_buffer_inst (
        .clk_int   (clk_int),
        .rst_n     (rst_n_int),
        .sub_addr  (sub_addr),
        .sub_ce    (sub_ce),
        .sub_we    (sub_we),
        .sub_wdata (sub_wdata),
        .sub_len   (sub_len),
        .sub_recv  (sub_recv),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .msg_len   (msg_len),
        .leds      (leds)
    );

    period_timer period_timer_inst (
        .clk_int (clk_int),
        .rst_n   (rst_n_int),
        .en      (pub_en),
        .period  (pub_period),
        .tick    (tick)
    );

    relay_fsm relay_fsm_inst (
        .clk_int    (clk_int),
        .rst_n      (rst_n_int),
        .tick       (tick),
        .msg_len    (msg_len),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .pub_valid  (pub_valid),
        .pub_last   (pub_last),
        .pub_byte   (pub_byte),
        .drop_count (drop_count)
    );

    // Release needs lock held across the whole synchroniser depth
    assert property (@(posedge clk_int) disable iff (!rst_n)
                     $rose(rst_n_int) |-> $past(pll_locked, 1)
                                          && $past(pll_locked, RST_SYNC_STAGES))
        else $error("relay_top: internal reset released without stable lock");

endmodule

`default_nettype wire
